// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN      = 32;
    localparam int TAG_W     = 6;                  // Reorder tag
    localparam int NUM_UNITS = 3;
    localparam int UNIT_W    = 2;                  // Wide enough for a unit index

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_func_t;

    // Values follow the BRANCH funct3 field
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_NONE = 3'b010,                          // Slot unused by BRANCH
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_func_t;

    typedef struct packed {
        logic [6:0] funct7;                        // Bit 30 picks SUB and SRA
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic       imm12;                         // Sign bit of the offset
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    // One instruction word seen through three formats
    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
    } inst_t;

endpackage

// ==== verilog/exec_ifs.sv ====
`timescale 1ns/100ps

// Router to one functional unit
interface unit_issue_if import exec_pkg::*; ();

    logic             en;                          // One-cycle pulse
    logic [XLEN-1:0]  opa;
    logic [XLEN-1:0]  opb;
    alu_func_t        alu_func;
    br_func_t         br_func;
    logic [XLEN-1:0]  cmp_a;                       // Branch compare operands
    logic [XLEN-1:0]  cmp_b;
    logic [TAG_W-1:0] tag;
    logic             busy;                        // Level

    modport router (
        output en, opa, opb, alu_func, br_func, cmp_a, cmp_b, tag,
        input  busy
    );

    modport unit (
        input  en, opa, opb, alu_func, br_func, cmp_a, cmp_b, tag,
        output busy
    );

endinterface

// One functional unit to the CDB arbiter
interface unit_result_if import exec_pkg::*; ();

    logic             done;                        // Held until the edge after grant
    logic [XLEN-1:0]  value;
    logic [TAG_W-1:0] tag;
    logic             is_branch;
    logic             take;
    logic             grant;                       // One-cycle pulse

    modport unit (
        output done, value, tag, is_branch, take,
        input  grant
    );

    modport arbiter (
        input  done, value, tag, is_branch, take,
        output grant
    );

endinterface

// ==== verilog/issue_router.sv ====
`timescale 1ns/100ps

module issue_router import exec_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             issue_valid,
    input  inst_t            issue_inst,
    input  logic [XLEN-1:0]  issue_rs1,
    input  logic [XLEN-1:0]  issue_rs2,
    input  logic [XLEN-1:0]  issue_pc,
    input  logic [TAG_W-1:0] issue_tag,
    output logic             issue_ready,
    unit_issue_if.router     units [NUM_UNITS]
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 alt;                     // Instruction bit 30
    logic [XLEN-1:0]      imm_i;
    logic [XLEN-1:0]      imm_b;
    alu_func_t            f3_func;                 // Function implied by funct3 alone
    alu_func_t            alu_func;
    br_func_t             br_func;
    logic [XLEN-1:0]      opa;
    logic [XLEN-1:0]      opb;
    logic [XLEN-1:0]      cmp_a;
    logic [XLEN-1:0]      cmp_b;
    logic [NUM_UNITS-1:0] busy_vec;
    logic [NUM_UNITS-1:0] idle_vec;
    logic [NUM_UNITS-1:0] pick;
    logic [NUM_UNITS-1:0] en_vec;

    assign opcode = issue_inst.r.opcode;
    assign funct3 = issue_inst.r.funct3;
    assign alt    = issue_inst.r.funct7[5];
    assign imm_i  = {{(XLEN-12){issue_inst.i.imm[11]}}, issue_inst.i.imm};
    assign imm_b  = {{(XLEN-12){issue_inst.b.imm12}}, issue_inst.b.imm11,
                     issue_inst.b.imm10_5, issue_inst.b.imm4_1, 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  f3_func = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;  // ADDI ignores bit 30
            3'b001:  f3_func = ALU_SLL;
            3'b010:  f3_func = ALU_SLT;
            3'b011:  f3_func = ALU_SLTU;
            3'b100:  f3_func = ALU_XOR;
            3'b101:  f3_func = alt ? ALU_SRA : ALU_SRL;   // Same bit for SRAI
            3'b110:  f3_func = ALU_OR;
            default: f3_func = ALU_AND;
        endcase
    end

    always_comb begin
        alu_func = ALU_ADD;
        br_func  = BR_NONE;
        opa      = '0;
        opb      = '0;
        cmp_a    = '0;
        cmp_b    = '0;
        case (opcode)
            OPC_OP: begin
                alu_func = f3_func;
                opa      = issue_rs1;
                opb      = issue_rs2;
            end
            OPC_OP_IMM: begin
                alu_func = f3_func;
                opa      = issue_rs1;
                opb      = imm_i;
            end
            OPC_BRANCH: begin
                opa     = issue_pc;                // Target is pc plus offset
                opb     = imm_b;
                cmp_a   = issue_rs1;
                cmp_b   = issue_rs2;
                br_func = (funct3[2:1] == 2'b01) ? BR_NONE : br_func_t'(funct3);
            end
            default: begin
            end
        endcase
    end

    assign idle_vec    = ~busy_vec;
    assign pick        = idle_vec & (~idle_vec + NUM_UNITS'(1));  // Lowest idle unit
    assign issue_ready = |idle_vec;

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_route
        assign busy_vec[g]       = units[g].busy;
        assign en_vec[g]         = issue_valid & pick[g];
        assign units[g].en       = en_vec[g];
        assign units[g].opa      = opa;
        assign units[g].opb      = opb;
        assign units[g].alu_func = alu_func;
        assign units[g].br_func  = br_func;
        assign units[g].cmp_a    = cmp_a;
        assign units[g].cmp_b    = cmp_b;
        assign units[g].tag      = issue_tag;

        // A routed instruction must occupy its unit from the next cycle
        en_occupies: assert property (@(posedge clock) disable iff (reset)
            en_vec[g] |=> busy_vec[g]);
    end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit import exec_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    unit_issue_if.unit  iss,
    unit_result_if.unit res
);

    logic [XLEN-1:0]        opa_q;
    logic [XLEN-1:0]        opb_q;
    logic [XLEN-1:0]        cmp_a_q;
    logic [XLEN-1:0]        cmp_b_q;
    logic signed [XLEN-1:0] signed_opa;
    logic signed [XLEN-1:0] signed_opb;
    logic signed [XLEN-1:0] signed_cmp_a;
    logic signed [XLEN-1:0] signed_cmp_b;
    alu_func_t              alu_func_q;
    br_func_t               br_func_q;
    logic [TAG_W-1:0]       tag_q;
    logic                   pend;                  // Operands held, result due next edge
    logic                   done;
    logic [XLEN-1:0]        alu_out;
    logic                   cond;
    logic [XLEN-1:0]        value_q;
    logic                   take_q;
    logic                   branch_q;

    assign signed_opa   = opa_q;
    assign signed_opb   = opb_q;
    assign signed_cmp_a = cmp_a_q;
    assign signed_cmp_b = cmp_b_q;

    always_ff @(posedge clock) begin
        if (iss.en) begin
            opa_q      <= iss.opa;
            opb_q      <= iss.opb;
            cmp_a_q    <= iss.cmp_a;
            cmp_b_q    <= iss.cmp_b;
            alu_func_q <= iss.alu_func;
            br_func_q  <= iss.br_func;
            tag_q      <= iss.tag;
        end
    end

    always_comb begin
        case (alu_func_q)
            ALU_ADD:  alu_out = opa_q + opb_q;
            ALU_SUB:  alu_out = opa_q - opb_q;
            ALU_AND:  alu_out = opa_q & opb_q;
            ALU_OR:   alu_out = opa_q | opb_q;
            ALU_XOR:  alu_out = opa_q ^ opb_q;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, signed_opa < signed_opb};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, opa_q < opb_q};
            ALU_SLL:  alu_out = opa_q << opb_q[4:0];
            ALU_SRL:  alu_out = opa_q >> opb_q[4:0];
            ALU_SRA:  alu_out = signed_opa >>> opb_q[4:0];
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        case (br_func_q)
            BR_BEQ:  cond = cmp_a_q == cmp_b_q;
            BR_BNE:  cond = cmp_a_q != cmp_b_q;
            BR_BLT:  cond = signed_cmp_a < signed_cmp_b;
            BR_BGE:  cond = signed_cmp_a >= signed_cmp_b;
            BR_BLTU: cond = cmp_a_q < cmp_b_q;
            BR_BGEU: cond = cmp_a_q >= cmp_b_q;
            default: cond = 1'b0;                  // Not a branch
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pend <= 1'b0;
            done <= 1'b0;
        end else begin
            pend <= iss.en;
            if (pend) begin
                done <= 1'b1;
            end else if (res.grant) begin
                done <= 1'b0;
            end
        end
    end

    // Result hold until the bus takes it
    always_ff @(posedge clock) begin
        if (pend) begin
            value_q  <= alu_out;
            take_q   <= cond;
            branch_q <= br_func_q != BR_NONE;
        end
    end

    assign iss.busy      = pend | done;
    assign res.done      = done;
    assign res.value     = value_q;
    assign res.tag       = tag_q;
    assign res.is_branch = branch_q;
    assign res.take      = take_q;

    no_en_while_busy: assert property (@(posedge clock) disable iff (reset)
        iss.en |-> !iss.busy);

    // Result stays put while it waits for the bus
    held_until_grant: assert property (@(posedge clock) disable iff (reset)
        done && !res.grant |=> done && $stable(value_q) && $stable(tag_q));

endmodule

// ==== verilog/cdb_arbiter.sv ====
`timescale 1ns/100ps

module cdb_arbiter import exec_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              cdb_free,
    unit_result_if.arbiter    units [NUM_UNITS],
    output logic              cdb_valid,
    output logic              cdb_branch,
    output logic              cdb_take,
    output logic [TAG_W-1:0]  cdb_tag,
    output logic [XLEN-1:0]   cdb_value
);

    logic [NUM_UNITS-1:0] done_vec;
    logic [NUM_UNITS-1:0] branch_vec;
    logic [NUM_UNITS-1:0] take_vec;
    logic [XLEN-1:0]      value_arr [NUM_UNITS];
    logic [TAG_W-1:0]     tag_arr [NUM_UNITS];
    logic [UNIT_W-1:0]    ptr;                     // Last granted unit
    logic [UNIT_W-1:0]    pick_idx;
    logic                 pick_any;
    logic                 grant;
    logic [NUM_UNITS-1:0] grant_vec;

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_collect
        assign done_vec[g]    = units[g].done;
        assign branch_vec[g]  = units[g].is_branch;
        assign take_vec[g]    = units[g].take;
        assign value_arr[g]   = units[g].value;
        assign tag_arr[g]     = units[g].tag;
        assign units[g].grant = grant_vec[g];
    end

    // Search starts one past the last winner
    always_comb begin
        int idx;
        pick_any = 1'b0;
        pick_idx = '0;
        for (int k = 1; k <= NUM_UNITS; k++) begin
            idx = (int'(ptr) + k) % NUM_UNITS;
            if (!pick_any && done_vec[idx]) begin
                pick_any = 1'b1;
                pick_idx = UNIT_W'(idx);
            end
        end
    end

    assign grant     = cdb_free & pick_any;
    assign grant_vec = grant ? (NUM_UNITS'(1) << pick_idx) : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
            ptr       <= UNIT_W'(NUM_UNITS - 1);  // Unit 0 first after reset
        end else begin
            cdb_valid <= grant;
            if (grant) begin
                ptr <= pick_idx;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (grant) begin
            cdb_tag    <= tag_arr[pick_idx];
            cdb_value  <= value_arr[pick_idx];
            cdb_branch <= branch_vec[pick_idx];
            cdb_take   <= take_vec[pick_idx];
        end
    end

    grant_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(grant_vec) && (grant_vec & ~done_vec) == '0);

endmodule

// ==== verilog/exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage import exec_pkg::*; (
    input  logic             clock,
    input  logic             reset,

    // Issue port
    input  logic             issue_valid,
    input  inst_t            issue_inst,
    input  logic [XLEN-1:0]  issue_rs1,
    input  logic [XLEN-1:0]  issue_rs2,
    input  logic [XLEN-1:0]  issue_pc,
    input  logic [TAG_W-1:0] issue_tag,
    output logic             issue_ready,

    // Common data bus
    input  logic             cdb_free,
    output logic             cdb_valid,
    output logic [TAG_W-1:0] cdb_tag,
    output logic [XLEN-1:0]  cdb_value,
    output logic             cdb_branch,
    output logic             cdb_take
);

    unit_issue_if  iss_if [NUM_UNITS] ();
    unit_result_if res_if [NUM_UNITS] ();

    issue_router u_issue_router (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_pc    (issue_pc),
        .issue_tag   (issue_tag),
        .issue_ready (issue_ready),
        .units       (iss_if)
    );

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_unit
        exec_unit u_exec_unit (
            .clock (clock),
            .reset (reset),
            .iss   (iss_if[g]),
            .res   (res_if[g])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .clock      (clock),
        .reset      (reset),
        .cdb_free   (cdb_free),
        .units      (res_if),
        .cdb_valid  (cdb_valid),
        .cdb_branch (cdb_branch),
        .cdb_take   (cdb_take),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value)
    );

endmodule

// ==== tests/exec_stage_tb.sv ====
`timescale 1ns/100ps

module exec_stage_tb import exec_pkg::*; ();

    localparam int MAX_ITEMS = 64;                 // One slot per possible tag

    logic             clock;
    logic             reset;
    logic             issue_valid;
    inst_t            issue_inst;
    logic [XLEN-1:0]  issue_rs1;
    logic [XLEN-1:0]  issue_rs2;
    logic [XLEN-1:0]  issue_pc;
    logic [TAG_W-1:0] issue_tag;
    logic             issue_ready;
    logic             cdb_free;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0]  cdb_value;
    logic             cdb_branch;
    logic             cdb_take;

    logic [31:0]      inst_arr [MAX_ITEMS];        // Indexed by file line
    logic [31:0]      rs1_arr [MAX_ITEMS];
    logic [31:0]      rs2_arr [MAX_ITEMS];
    logic [31:0]      pc_arr [MAX_ITEMS];
    logic [TAG_W-1:0] tag_arr [MAX_ITEMS];
    logic [31:0]      exp_value [MAX_ITEMS];       // Indexed by tag
    logic             exp_branch [MAX_ITEMS];
    logic             exp_take [MAX_ITEMS];
    logic             issued [MAX_ITEMS];
    int               seen_cnt [MAX_ITEMS];
    int               n_items = 0;
    int               seen_count = 0;
    logic             hold_low = 1'b1;             // Forces the bus busy
    logic             free_before = 1'b0;
    logic [31:0]      rng = 32'h4819;

    exec_stage u_exec_stage (.*);

    always #5 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f_inst, f_rs1, f_rs2, f_pc, f_tag, f_val, f_br, f_tk;
        fd = $fopen("tests/exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("The stimulus file could not be opened");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin    // Skip column notes
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                              f_inst, f_rs1, f_rs2, f_pc, f_tag, f_val, f_br, f_tk);
                if (cnt == 8 && n_items < MAX_ITEMS) begin
                    inst_arr[n_items]   = f_inst;
                    rs1_arr[n_items]    = f_rs1;
                    rs2_arr[n_items]    = f_rs2;
                    pc_arr[n_items]     = f_pc;
                    tag_arr[n_items]    = f_tag[TAG_W-1:0];
                    exp_value[f_tag]    = f_val;
                    exp_branch[f_tag]   = f_br[0];
                    exp_take[f_tag]     = f_tk[0];
                    n_items++;
                end
            end
        end
        $fclose(fd);
        if (n_items < NUM_UNITS) begin
            $display("The stimulus file holds too few instructions");
            abort_run();
        end
    endtask

    // Drive one line and hold it until a unit is idle
    task automatic issue_one(input int idx);
        int waited;
        @(posedge clock);
        issue_valid <= 1'b1;
        issue_inst  <= inst_arr[idx];
        issue_rs1   <= rs1_arr[idx];
        issue_rs2   <= rs2_arr[idx];
        issue_pc    <= pc_arr[idx];
        issue_tag   <= tag_arr[idx];
        waited = 0;
        @(negedge clock);
        while (!issue_ready) begin
            waited++;
            if (waited > 200) begin
                $display("Timed out waiting for issue_ready at line %0d", idx);
                abort_run();
            end
            @(negedge clock);
        end
        issued[tag_arr[idx]] = 1'b1;               // Taken at the coming edge
    endtask

    task automatic wait_for_results(input int target, input string what);
        int waited;
        waited = 0;
        while (seen_count < target) begin
            @(posedge clock);
            waited++;
            if (waited > 1000) begin
                $display("Timed out waiting for the %s", what);
                abort_run();
            end
        end
    endtask

    always @(posedge clock) begin
        rng = xorshift(rng);
        cdb_free <= hold_low ? 1'b0 : (rng[1:0] != 2'b00);   // Low about one cycle in four
    end

    // Bus monitor
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            if (!free_before) begin
                $display("A result appeared on the bus after a cycle with cdb_free low");
                abort_run();
            end
            if (!issued[cdb_tag] || seen_cnt[cdb_tag] != 0) begin
                $display("Tag %h appeared on the bus unissued or a second time", cdb_tag);
                abort_run();
            end
            check_value("cdb_value", cdb_value, exp_value[cdb_tag]);
            check_value("cdb_branch", cdb_branch, exp_branch[cdb_tag]);
            check_value("cdb_take", cdb_take, exp_take[cdb_tag]);
            seen_cnt[cdb_tag]++;
            seen_count++;
        end
        free_before = cdb_free;
    end

    initial begin
        int i;
        clock       = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_inst  = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_pc    = '0;
        issue_tag   = '0;
        cdb_free    = 1'b0;
        for (i = 0; i < MAX_ITEMS; i++) begin
            issued[i]   = 1'b0;
            seen_cnt[i] = 0;
        end
        load_stimulus();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("cdb_valid", cdb_valid, 1'b0);
        check_value("issue_ready", issue_ready, 1'b1);

        // Bus held busy, so the units fill up and stay full
        for (i = 0; i < NUM_UNITS; i++) begin
            issue_one(i);
        end
        @(posedge clock);
        issue_valid <= 1'b0;
        repeat (8) begin
            @(negedge clock);
            check_value("issue_ready", issue_ready, 1'b0);
        end
        hold_low = 1'b0;
        wait_for_results(NUM_UNITS, "results held during the stall");

        for (i = NUM_UNITS; i < n_items; i++) begin
            issue_one(i);
        end
        @(posedge clock);
        issue_valid <= 1'b0;
        wait_for_results(n_items, "last results");
        repeat (10) @(negedge clock);
        check_value("issue_ready", issue_ready, 1'b1);    // Every unit idle again

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - verilog/exec_pkg.sv
  - verilog/exec_ifs.sv
  - verilog/issue_router.sv
  - verilog/exec_unit.sv
  - verilog/cdb_arbiter.sv
  - verilog/exec_stage.sv
  - target: test
    files:
      - tests/exec_stage_tb.sv

// ==== list.f ====
verilog/exec_pkg.sv
verilog/exec_ifs.sv
verilog/issue_router.sv
verilog/exec_unit.sv
verilog/cdb_arbiter.sv
verilog/exec_stage.sv
tests/exec_stage_tb.sv

// ==== tests/exec_stimulus.txt ====
# inst rs1 rs2 pc tag | expected: value branch take (all hex)
# Tags 00-02 are issued while the bus is held, the rest with random stalls
003100B3 00000005 00000007 00000000 00 0000000C 0 0
403100B3 00000005 00000007 00000000 01 FFFFFFFE 0 0
003110B3 00000001 00000024 00000000 02 00000010 0 0
003120B3 FFFFFFFF 00000001 00000000 03 00000001 0 0
003130B3 FFFFFFFF 00000001 00000000 04 00000000 0 0
003140B3 F0F0F0F0 0FF00FF0 00000000 05 FF00FF00 0 0
003150B3 80000000 00000004 00000000 06 08000000 0 0
403150B3 80000000 00000004 00000000 07 F8000000 0 0
003160B3 12340000 00005678 00000000 08 12345678 0 0
003170B3 FFFF00FF 0F0F0F0F 00000000 09 0F0F000F 0 0
403150B3 80000000 00000023 00000000 0A F0000000 0 0
FFD10093 00000010 00000000 00000000 0B 0000000D 0 0
FFF12093 FFFFFFFE 00000000 00000000 0C 00000001 0 0
FFF13093 00000005 00000000 00000000 0D 00000001 0 0
0FF14093 00000F0F 00000000 00000000 0E 00000FF0 0 0
70016093 00000055 00000000 00000000 0F 00000755 0 0
0F017093 12345678 00000000 00000000 10 00000070 0 0
00811093 000000AB 00000000 00000000 11 0000AB00 0 0
00815093 F0000000 00000000 00000000 12 00F00000 0 0
40815093 F0000000 00000000 00000000 13 FFF00000 0 0
00310863 00000007 00000007 00001000 14 00001010 1 1
00311863 00000007 00000007 00001000 15 00001010 1 0
FE314CE3 FFFFFFFF 00000001 00001000 16 00000FF8 1 1
FE315CE3 FFFFFFFF 00000001 00001000 17 00000FF8 1 0
00316863 FFFFFFFF 00000001 00001000 18 00001010 1 0
00317863 FFFFFFFF 00000001 00001000 19 00001010 1 1
00314863 80000000 7FFFFFFF 00002000 1A 00002010 1 1
00316863 80000000 7FFFFFFF 00002000 1B 00002010 1 0
FE315CE3 80000000 80000000 00002000 1C 00001FF8 1 1
123450B7 00000011 00000022 00003000 1D 00000000 0 0
